// File: Bender.yml
package:
  name: mem_pipe

sources:
  - include_dirs:
      - design
    files:
      - design/mem_pipe_pkg.sv
      - design/mem_pipe_if.sv
      - design/mem_decode.sv
      - design/mem_execute.sv
      - design/mem_result.sv
      - design/mem_pipe_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/mem_pipe_checker.sv
      - test/mem_pipe_tb.sv

// File: design/mem_config.svh
// Memory pipe configuration: data path width, data array depth and register address width
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Data path width in bits
`define MEM_DWORD_WIDTH 64

// Number of 64-bit words in the data array (512 bytes)
`define MEM_DEPTH 64

// Destination register number width
`define MEM_RD_ADDR_WIDTH 5

`endif

// File: design/mem_decode.sv
// Memory pipe decode stage, registers a request and classifies its opcode
`timescale 1ns/100ps

module mem_decode
  (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   req_v_i,
    input  mem_pipe_pkg::mem_op_e  op_i,
    input  mem_pipe_pkg::dword_t   rs1_i,
    input  mem_pipe_pkg::dword_t   rs2_i,
    input  mem_pipe_pkg::dword_t   imm_i,
    input  mem_pipe_pkg::rd_addr_t rd_addr_i,
    mem_req_if.dec                 req
  );
  import mem_pipe_pkg::*;

  logic      is_load;
  logic      is_store;
  logic      is_unsigned;
  mem_size_e size;

  assign is_load     = op_i inside {e_op_lb, e_op_lbu, e_op_lh, e_op_lhu,
                                    e_op_lw, e_op_lwu, e_op_ld};
  assign is_store    = op_i inside {e_op_sb, e_op_sh, e_op_sw, e_op_sd};
  assign is_unsigned = op_i inside {e_op_lbu, e_op_lhu, e_op_lwu};

  // Access size from the opcode, anything else is a double word
  always_comb
  begin
    case (op_i)
      e_op_lb, e_op_lbu, e_op_sb:
        size = e_size_b;
      e_op_lh, e_op_lhu, e_op_sh:
        size = e_size_h;
      e_op_lw, e_op_lwu, e_op_sw:
        size = e_size_w;
      default:
        size = e_size_d;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      req.v <= 1'b0;
    end
    else
    begin
      req.v <= req_v_i;
    end
  end

  // Decoded fields and operands, qualified downstream by v
  always_ff @(posedge clk_i)
  begin
    req.is_load     <= is_load;
    req.is_store    <= is_store;
    req.is_unsigned <= is_unsigned;
    req.size        <= size;
    req.rs1         <= rs1_i;
    req.rs2         <= rs2_i;
    req.imm         <= imm_i;
    req.rd_addr     <= rd_addr_i;
  end

endmodule

// File: design/mem_execute.sv
// Memory pipe execute stage with address generation, alignment check and the data array
`timescale 1ns/100ps
`include "mem_config.svh"

module mem_execute
  (
    input  logic   clk_i,
    input  logic   rst_i,
    mem_req_if.exe req,
    mem_rsp_if.exe rsp
  );
  import mem_pipe_pkg::*;

  dword_t     mem_q [`MEM_DEPTH];
  eaddr_t     eaddr;
  word_idx_t  word_idx;
  byte_off_t  byte_off;
  logic       misaligned;
  logic [7:0] size_mask;
  logic [7:0] byte_en;
  dword_t     wdata;
  logic       do_write;
  logic       do_read;

  assign eaddr = req.rs1 + req.imm;

  // Upper address bits drop out, so the array wraps every 512 bytes
  assign word_idx = eaddr[3 +: $bits(word_idx_t)];
  assign byte_off = eaddr[2:0];

  always_comb
  begin
    case (req.size)
      e_size_b:
      begin
        misaligned = 1'b0;
        size_mask  = 8'h01;
      end
      e_size_h:
      begin
        misaligned = byte_off[0];
        size_mask  = 8'h03;
      end
      e_size_w:
      begin
        misaligned = |byte_off[1:0];
        size_mask  = 8'h0f;
      end
      default:
      begin
        misaligned = |byte_off;
        size_mask  = 8'hff;
      end
    endcase
  end

  // Lane placement of store data, never overflows once aligned
  assign byte_en = size_mask << byte_off;
  assign wdata   = req.rs2 << {byte_off, 3'b000};

  assign do_write = req.v & req.is_store & ~misaligned;
  assign do_read  = req.v & req.is_load & ~misaligned;

  always_ff @(posedge clk_i)
  begin
    if (do_write)
    begin
      for (int i = 0; i < 8; i++)
      begin
        if (byte_en[i])
          mem_q[word_idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rsp.v                <= 1'b0;
      rsp.load_misaligned  <= 1'b0;
      rsp.store_misaligned <= 1'b0;
    end
    else
    begin
      rsp.v                <= req.v;
      rsp.load_misaligned  <= req.v & req.is_load & misaligned;
      rsp.store_misaligned <= req.v & req.is_store & misaligned;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rsp.is_load     <= req.is_load;
    rsp.size        <= req.size;
    rsp.is_unsigned <= req.is_unsigned;
    rsp.byte_off    <= byte_off;
    rsp.rd_addr     <= req.rd_addr;
    if (do_read)
      rsp.raw_data <= mem_q[word_idx];
  end

endmodule

// File: design/mem_pipe_if.sv
// Memory pipe stage interfaces: decoded request into execute and array response into result
`timescale 1ns/100ps

interface mem_req_if;
  import mem_pipe_pkg::*;

  logic      v;
  logic      is_load;
  logic      is_store;
  mem_size_e size;
  logic      is_unsigned;
  dword_t    rs1;
  dword_t    rs2;
  dword_t    imm;
  rd_addr_t  rd_addr;

  modport dec
  (
    output v, is_load, is_store, size, is_unsigned,
    output rs1, rs2, imm, rd_addr
  );

  modport exe
  (
    input v, is_load, is_store, size, is_unsigned,
    input rs1, rs2, imm, rd_addr
  );

endinterface

interface mem_rsp_if;
  import mem_pipe_pkg::*;

  logic      v;
  logic      is_load;
  mem_size_e size;
  logic      is_unsigned;
  byte_off_t byte_off;
  dword_t    raw_data;
  rd_addr_t  rd_addr;
  logic      load_misaligned;
  logic      store_misaligned;

  modport exe
  (
    output v, is_load, size, is_unsigned, byte_off,
    output raw_data, rd_addr, load_misaligned, store_misaligned
  );

  modport res
  (
    input v, is_load, size, is_unsigned, byte_off,
    input raw_data, rd_addr, load_misaligned, store_misaligned
  );

endinterface

// File: design/mem_pipe_pkg.sv
// Memory pipe shared types: data and address widths, opcode and access size encodings
`include "mem_config.svh"

package mem_pipe_pkg;

  typedef logic [`MEM_DWORD_WIDTH-1:0]   dword_t;
  typedef logic [63:0]                   eaddr_t;
  typedef logic [`MEM_RD_ADDR_WIDTH-1:0] rd_addr_t;
  typedef logic [$clog2(`MEM_DEPTH)-1:0] word_idx_t;
  typedef logic [2:0]                    byte_off_t;

  // Memory opcodes, loads first
  typedef enum logic [3:0]
  {
    e_op_lb  = 4'h0,
    e_op_lbu = 4'h1,
    e_op_lh  = 4'h2,
    e_op_lhu = 4'h3,
    e_op_lw  = 4'h4,
    e_op_lwu = 4'h5,
    e_op_ld  = 4'h6,
    e_op_sb  = 4'h7,
    e_op_sh  = 4'h8,
    e_op_sw  = 4'h9,
    e_op_sd  = 4'ha
  } mem_op_e;

  // Access size, log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_b = 2'b00,
    e_size_h = 2'b01,
    e_size_w = 2'b10,
    e_size_d = 2'b11
  } mem_size_e;

endpackage

// File: design/mem_pipe_top.sv
// Memory pipe top level connecting decode, execute and result through the stage interfaces
`timescale 1ns/100ps

module mem_pipe_top
  (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   req_v_i,
    input  mem_pipe_pkg::mem_op_e  op_i,
    input  mem_pipe_pkg::dword_t   rs1_i,
    input  mem_pipe_pkg::dword_t   rs2_i,
    input  mem_pipe_pkg::dword_t   imm_i,
    input  mem_pipe_pkg::rd_addr_t rd_addr_i,

    output logic                   load_v_o,
    output mem_pipe_pkg::dword_t   load_data_o,
    output mem_pipe_pkg::rd_addr_t load_rd_addr_o,
    output logic                   load_misaligned_o,
    output logic                   store_misaligned_o
  );

  mem_req_if u_req_if ();
  mem_rsp_if u_rsp_if ();

  // Stage one, request capture and opcode decode
  mem_decode u_decode
  (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_v_i   (req_v_i),
    .op_i      (op_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .imm_i     (imm_i),
    .rd_addr_i (rd_addr_i),
    .req       (u_req_if.dec)
  );

  // Stage two, address and data array access
  mem_execute u_execute
  (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req   (u_req_if.exe),
    .rsp   (u_rsp_if.exe)
  );

  mem_result u_result
  (
    .rsp                (u_rsp_if.res),
    .load_v_o           (load_v_o),
    .load_data_o        (load_data_o),
    .load_rd_addr_o     (load_rd_addr_o),
    .load_misaligned_o  (load_misaligned_o),
    .store_misaligned_o (store_misaligned_o)
  );

endmodule

// File: design/mem_result.sv
// Memory pipe result stage, aligns and extends load data and drives the pipe outputs
`timescale 1ns/100ps

module mem_result
  (
    mem_rsp_if.res                  rsp,
    output logic                    load_v_o,
    output mem_pipe_pkg::dword_t    load_data_o,
    output mem_pipe_pkg::rd_addr_t  load_rd_addr_o,
    output logic                    load_misaligned_o,
    output logic                    store_misaligned_o
  );
  import mem_pipe_pkg::*;

  dword_t shifted;
  logic   sext;

  // Bring the addressed byte down to lane zero
  assign shifted = rsp.raw_data >> {rsp.byte_off, 3'b000};

  always_comb
  begin
    case (rsp.size)
      e_size_b:
        sext = ~rsp.is_unsigned & shifted[7];
      e_size_h:
        sext = ~rsp.is_unsigned & shifted[15];
      e_size_w:
        sext = ~rsp.is_unsigned & shifted[31];
      default:
        sext = 1'b0;
    endcase
  end

  always_comb
  begin
    case (rsp.size)
      e_size_b:
        load_data_o = {{56{sext}}, shifted[7:0]};
      e_size_h:
        load_data_o = {{48{sext}}, shifted[15:0]};
      e_size_w:
        load_data_o = {{32{sext}}, shifted[31:0]};
      default:
        load_data_o = shifted;
    endcase
  end

  // A faulting load never reports data
  assign load_v_o           = rsp.v & rsp.is_load & ~rsp.load_misaligned;
  assign load_rd_addr_o     = rsp.rd_addr;
  assign load_misaligned_o  = rsp.v & rsp.load_misaligned;
  assign store_misaligned_o = rsp.v & rsp.store_misaligned;

endmodule

// File: flist.f
+incdir+design
design/mem_pipe_pkg.sv
design/mem_pipe_if.sv
design/mem_decode.sv
design/mem_execute.sv
design/mem_result.sv
design/mem_pipe_top.sv
test/mem_pipe_checker.sv
test/mem_pipe_tb.sv

// File: test/mem_pipe_checker.sv
// Memory pipe assertions on output strobe exclusivity, reset state and result latency
`timescale 1ns/100ps

module mem_pipe_checker
  (
    input logic clk_i,
    input logic rst_i,
    input logic req_v_i,
    input logic load_v_o,
    input logic load_misaligned_o,
    input logic store_misaligned_o
  );

  int unsigned assert_fails = 0;

  // At most one result strobe per cycle
  a_strobes_exclusive : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({load_v_o, load_misaligned_o, store_misaligned_o}))
  else
  begin
    assert_fails++;
    $error("More than one result strobe is high in the same cycle");
  end

  a_reset_quiet : assert property (@(posedge clk_i)
    rst_i |=> !(load_v_o || load_misaligned_o || store_misaligned_o))
  else
  begin
    assert_fails++;
    $error("A result strobe is high in the cycle after reset");
  end

  // Every strobe traces back to a request two cycles earlier
  a_fixed_latency : assert property (@(posedge clk_i) disable iff (rst_i)
    (load_v_o || load_misaligned_o || store_misaligned_o) |-> $past(req_v_i, 2))
  else
  begin
    assert_fails++;
    $error("A result strobe appeared without a request two cycles earlier");
  end

endmodule

bind mem_pipe_top mem_pipe_checker u_checker
(
  .clk_i              (clk_i),
  .rst_i              (rst_i),
  .req_v_i            (req_v_i),
  .load_v_o           (load_v_o),
  .load_misaligned_o  (load_misaligned_o),
  .store_misaligned_o (store_misaligned_o)
);

// File: test/mem_pipe_tb.sv
// Memory pipe testbench, table-driven stimulus checked against a byte-level reference memory
`timescale 1ns/100ps

module mem_pipe_tb;
  import mem_pipe_pkg::*;

  typedef struct packed
  {
    logic     v;
    mem_op_e  op;
    dword_t   rs1;
    dword_t   imm;
    dword_t   rs2;
    rd_addr_t rd;
  } stim_t;

  typedef struct packed
  {
    int       due;
    logic     load_v;
    logic     ld_mis;
    logic     st_mis;
    dword_t   data;
    rd_addr_t rd;
  } expect_t;

  logic     clk_i;
  logic     rst_i;
  logic     req_v_i;
  mem_op_e  op_i;
  dword_t   rs1_i;
  dword_t   rs2_i;
  dword_t   imm_i;
  rd_addr_t rd_addr_i;
  logic     load_v_o;
  dword_t   load_data_o;
  rd_addr_t load_rd_addr_o;
  logic     load_misaligned_o;
  logic     store_misaligned_o;

  stim_t       table_q [$];
  expect_t     exp_q [$];
  logic [7:0]  ref_mem [512];
  logic [31:0] lcg_state;
  int          cycle = 0;
  int          checks = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  logic        mon_en = 1'b0;

  mem_pipe_top u_dut
  (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .req_v_i            (req_v_i),
    .op_i               (op_i),
    .rs1_i              (rs1_i),
    .rs2_i              (rs2_i),
    .imm_i              (imm_i),
    .rd_addr_i          (rd_addr_i),
    .load_v_o           (load_v_o),
    .load_data_o        (load_data_o),
    .load_rd_addr_o     (load_rd_addr_o),
    .load_misaligned_o  (load_misaligned_o),
    .store_misaligned_o (store_misaligned_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int op_bytes(mem_op_e op);
    case (op)
      e_op_lb, e_op_lbu, e_op_sb: return 1;
      e_op_lh, e_op_lhu, e_op_sh: return 2;
      e_op_lw, e_op_lwu, e_op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic op_is_load(mem_op_e op);
    return op inside {e_op_lb, e_op_lbu, e_op_lh, e_op_lhu, e_op_lw, e_op_lwu, e_op_ld};
  endfunction

  function automatic logic op_is_unsigned(mem_op_e op);
    return op inside {e_op_lbu, e_op_lhu, e_op_lwu};
  endfunction

  task automatic check_value(input string name, input dword_t got, input dword_t exp);
    checks++;
    if (got !== exp)
    begin
      value_errs++;
      $display("Error: %s = 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic add_req(input mem_op_e op, input dword_t rs1, input dword_t imm,
                         input dword_t rs2);
    table_q.push_back('{1'b1, op, rs1, imm, rs2, rd_addr_t'(table_q.size())});
  endtask

  task automatic add_idle(input int n);
    repeat (n) table_q.push_back('{1'b0, e_op_lb, 64'h0, 64'h0, 64'h0, 5'h0});
  endtask

  task automatic build_table();
    dword_t rs1;
    int     t;
    add_idle(4);
    // Known contents for every double word of the array
    for (int w = 0; w < 64; w++)
      add_req(e_op_sd, dword_t'(8 * w), 64'h0, {lcg_next(), lcg_next()});
    // Sized stores merged into one double word
    add_req(e_op_sd, 64'h100, 64'h0, 64'h1122_3344_5566_7788);
    add_req(e_op_sb, 64'h100, 64'h3, 64'hab);
    add_req(e_op_ld, 64'h100, 64'h0, 64'h0);
    add_req(e_op_sh, 64'h104, 64'h0, 64'hcdef);
    add_req(e_op_ld, 64'h100, 64'h0, 64'h0);
    add_req(e_op_sw, 64'h0fc, 64'h4, 64'h89ab_cdef);
    add_req(e_op_ld, 64'h100, 64'h0, 64'h0);
    add_req(e_op_sw, 64'h100, 64'h4, 64'h0bad_f00d);
    add_req(e_op_ld, 64'h100, 64'h0, 64'h0);
    // Sign and zero extension
    add_req(e_op_sd, 64'h108, 64'h0, 64'hfedc_ba98_8765_4381);
    add_req(e_op_lb, 64'h108, 64'h0, 64'h0);
    add_req(e_op_lbu, 64'h108, 64'h0, 64'h0);
    add_req(e_op_lb, 64'h109, 64'h0, 64'h0);
    add_req(e_op_lh, 64'h10a, 64'h0, 64'h0);
    add_req(e_op_lhu, 64'h10a, 64'h0, 64'h0);
    add_req(e_op_lw, 64'h10c, 64'h0, 64'h0);
    add_req(e_op_lwu, 64'h10c, 64'h0, 64'h0);
    add_req(e_op_lw, 64'h108, 64'h0, 64'h0);
    add_idle(1);
    // Misaligned accesses fault and leave the array alone
    add_req(e_op_lh, 64'h101, 64'h0, 64'h0);
    add_req(e_op_lw, 64'h102, 64'h0, 64'h0);
    add_req(e_op_ld, 64'h104, 64'h0, 64'h0);
    add_req(e_op_sh, 64'h103, 64'h0, 64'hffff);
    add_req(e_op_sw, 64'h106, 64'h0, 64'hffff_ffff);
    add_req(e_op_sd, 64'h109, 64'h0, 64'hffff_ffff_ffff_ffff);
    add_req(e_op_ld, 64'h100, 64'h0, 64'h0);
    add_req(e_op_ld, 64'h108, 64'h0, 64'h0);
    // Store followed by a load of it in the next cycle
    add_req(e_op_sd, 64'h118, 64'h0, 64'h0123_4567_89ab_cdef);
    add_req(e_op_lw, 64'h11c, 64'h0, 64'h0);
    add_req(e_op_sb, 64'h11d, 64'h0, 64'h5a);
    add_req(e_op_lbu, 64'h11d, 64'h0, 64'h0);
    add_req(e_op_sh, 64'h11e, 64'h0, 64'h9876);
    add_req(e_op_lh, 64'h11e, 64'h0, 64'h0);
    // Addresses past 511 wrap, a negative immediate included
    add_req(e_op_sd, 64'h1000_0000_0000_0120, 64'h0, 64'h5555_aaaa_3333_cccc);
    add_req(e_op_ld, 64'h120, 64'h0, 64'h0);
    add_req(e_op_sd, 64'h8, 64'hffff_ffff_ffff_fff0, 64'hdead_beef_cafe_f00d);
    add_req(e_op_ld, 64'h1f8, 64'h0, 64'h0);
    add_req(e_op_ld, 64'h300, 64'h28, 64'h0);
    add_req(e_op_lwu, 64'h200, 64'hffff_ffff_ffff_fffc, 64'h0);
    add_idle(2);
    // Random mix, about half of it forced aligned
    for (int k = 0; k < 48; k++)
    begin
      t = int'((lcg_next() >> 16) % 32'd64) - 32;
      rs1 = {lcg_next(), lcg_next()};
      if (((lcg_next() >> 16) % 32'd2) == 32'd0)
      begin
        rs1[2:0] = 3'b000;
        t = t & -8;
      end
      add_req(mem_op_e'(4'((lcg_next() >> 16) % 32'd11)), rs1, dword_t'(longint'(t)),
              {lcg_next(), lcg_next()});
    end
  endtask

  // Applies one request to the reference memory and queues what the outputs must show
  task automatic model_apply(input stim_t s);
    expect_t e;
    dword_t  eaddr;
    dword_t  val;
    dword_t  mask;
    int      n;
    int      a;
    logic    is_ld;
    logic    mis;
    n = op_bytes(s.op);
    is_ld = op_is_load(s.op);
    eaddr = s.rs1 + s.imm;
    a = int'(eaddr[8:0]);
    mis = |(eaddr & dword_t'(n - 1));
    e = '{cycle + 2, is_ld & ~mis, is_ld & mis, ~is_ld & mis, 64'h0, s.rd};
    if (e.load_v)
    begin
      mask = (n == 8) ? '1 : (dword_t'(1) << (8 * n)) - dword_t'(1);
      val = '0;
      for (int i = 0; i < n; i++)
        val[8*i +: 8] = ref_mem[a + i];
      if (!op_is_unsigned(s.op) && val[8*n-1])
        val = val | ~mask;
      e.data = val;
    end
    else if (!is_ld && !mis)
    begin
      for (int i = 0; i < n; i++)
        ref_mem[a + i] = s.rs2[8*i +: 8];
    end
    if (is_ld || mis)
      exp_q.push_back(e);
  endtask

  // Outputs only change at the rising edge, so the falling edge sees them settled
  initial
  begin
    expect_t e;
    forever
    begin
      @(negedge clk_i);
      if (mon_en)
      begin
        if (exp_q.size() != 0 && exp_q[0].due == cycle)
        begin
          e = exp_q.pop_front();
          check_value("load_v_o", dword_t'(load_v_o), dword_t'(e.load_v));
          check_value("load_misaligned_o", dword_t'(load_misaligned_o), dword_t'(e.ld_mis));
          check_value("store_misaligned_o", dword_t'(store_misaligned_o), dword_t'(e.st_mis));
          if (e.load_v)
          begin
            check_value("load_data_o", load_data_o, e.data);
            check_value("load_rd_addr_o", dword_t'(load_rd_addr_o), dword_t'(e.rd));
          end
        end
        else
        begin
          check_value("load_v_o", dword_t'(load_v_o), 64'h0);
          check_value("load_misaligned_o", dword_t'(load_misaligned_o), 64'h0);
          check_value("store_misaligned_o", dword_t'(store_misaligned_o), 64'h0);
        end
      end
    end
  end

  initial
  begin
    int waited;
    lcg_state = 32'd36524;
    rst_i = 1'b1;
    req_v_i = 1'b0;
    op_i = e_op_lb;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    rd_addr_i = '0;
    build_table();
    repeat (3) @(posedge clk_i);
    mon_en = 1'b1;
    @(negedge clk_i);
    rst_i = 1'b0;
    foreach (table_q[k])
    begin
      @(negedge clk_i);
      req_v_i = table_q[k].v;
      op_i = table_q[k].op;
      rs1_i = table_q[k].rs1;
      rs2_i = table_q[k].rs2;
      imm_i = table_q[k].imm;
      rd_addr_i = table_q[k].rd;
      if (table_q[k].v)
        model_apply(table_q[k]);
    end
    @(negedge clk_i);
    req_v_i = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20)
    begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      other_errs++;
      $display("Timeout: %0d expected results never appeared on the outputs", exp_q.size());
    end
    $display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             checks, value_errs, other_errs, u_dut.u_checker.assert_fails);
    if (value_errs == 0 && other_errs == 0 && u_dut.u_checker.assert_fails == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
